// ==== build.f ====
design/axil_pkg.sv
design/axil_spill_reg.sv
design/axil_cut.sv
design/axil_multicut.sv
design/axil_reg_ctrl.sv
design/axil_reg_bank.sv
design/axil_sub_top.sv
test/tb_axil_sub.sv

// ==== design/axil_cut.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_cut
  import axil_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t slv_req_i,
  output axil_rsp_t slv_rsp_o,
  output axil_req_t mst_req_o,
  input  axil_rsp_t mst_rsp_i
);

  // Write address, forward
  axil_spill_reg #(.chan_t(aw_chan_t)) i_aw_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_req_i.aw_valid),
    .ready_o (slv_rsp_o.aw_ready),
    .data_i  (slv_req_i.aw),
    .valid_o (mst_req_o.aw_valid),
    .ready_i (mst_rsp_i.aw_ready),
    .data_o  (mst_req_o.aw)
  );

  // Write data, forward
  axil_spill_reg #(.chan_t(w_chan_t)) i_w_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_req_i.w_valid),
    .ready_o (slv_rsp_o.w_ready),
    .data_i  (slv_req_i.w),
    .valid_o (mst_req_o.w_valid),
    .ready_i (mst_rsp_i.w_ready),
    .data_o  (mst_req_o.w)
  );

  // Write response, backward
  axil_spill_reg #(.chan_t(b_chan_t)) i_b_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (mst_rsp_i.b_valid),
    .ready_o (mst_req_o.b_ready),
    .data_i  (mst_rsp_i.b),
    .valid_o (slv_rsp_o.b_valid),
    .ready_i (slv_req_i.b_ready),
    .data_o  (slv_rsp_o.b)
  );

  // Read address, forward
  axil_spill_reg #(.chan_t(ar_chan_t)) i_ar_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_req_i.ar_valid),
    .ready_o (slv_rsp_o.ar_ready),
    .data_i  (slv_req_i.ar),
    .valid_o (mst_req_o.ar_valid),
    .ready_i (mst_rsp_i.ar_ready),
    .data_o  (mst_req_o.ar)
  );

  // Read data, backward
  axil_spill_reg #(.chan_t(r_chan_t)) i_r_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (mst_rsp_i.r_valid),
    .ready_o (mst_req_o.r_ready),
    .data_i  (mst_rsp_i.r),
    .valid_o (slv_rsp_o.r_valid),
    .ready_i (slv_req_i.r_ready),
    .data_o  (slv_rsp_o.r)
  );

endmodule

`default_nettype wire

// ==== design/axil_multicut.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_multicut
  import axil_pkg::*;
#(
  parameter int unsigned NumCuts = 1
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t slv_req_i,
  output axil_rsp_t slv_rsp_o,
  output axil_req_t mst_req_o,
  input  axil_rsp_t mst_rsp_i
);

  if (NumCuts == 0) begin : gen_no_cut
    assign mst_req_o = slv_req_i;
    assign slv_rsp_o = mst_rsp_i;
  end else begin : gen_cuts
    // Index 0 faces the manager, index NumCuts faces the target
    axil_req_t cut_req [0:NumCuts];
    axil_rsp_t cut_rsp [0:NumCuts];

    assign cut_req[0] = slv_req_i;
    assign slv_rsp_o  = cut_rsp[0];

    for (genvar i = 0; i < NumCuts; i++) begin : gen_cut
      axil_cut i_cut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .slv_req_i (cut_req[i]),
        .slv_rsp_o (cut_rsp[i]),
        .mst_req_o (cut_req[i+1]),
        .mst_rsp_i (cut_rsp[i+1])
      );
    end

    assign mst_req_o        = cut_req[NumCuts];
    assign cut_rsp[NumCuts] = mst_rsp_i;
  end

endmodule

`default_nettype wire

// ==== design/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

  // Bus geometry
  localparam int unsigned ADDR_WIDTH = 12;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // Byte offset bits below the word index
  localparam int unsigned BYTE_OFFSET = $clog2(STRB_WIDTH);

  // Register bank size
  localparam int unsigned NUM_REGS      = 16;
  localparam int unsigned REG_IDX_WIDTH = 4;

  // Pipeline cuts between the top boundary and the controller
  localparam int unsigned NUM_CUTS = 2;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [1:0]            resp_t_code;

  localparam resp_t_code RESP_OKAY   = 2'b00;
  localparam resp_t_code RESP_SLVERR = 2'b10;

  // Channel payloads
  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t_code resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t      data;
    resp_t_code resp;
  } r_chan_t;

  // Manager to target
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // Target to manager
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== design/axil_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_reg_bank
  import axil_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wr_en_i,
  input  logic [REG_IDX_WIDTH-1:0] wr_idx_i,
  input  data_t                    wr_data_i,
  input  strb_t                    wr_strb_i,
  input  logic                     rd_en_i,
  input  logic [REG_IDX_WIDTH-1:0] rd_idx_i,
  output data_t                    rd_data_o
);

  data_t regs_q [NUM_REGS];
  data_t rd_data_q;

  // Byte lanes follow the strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wr_strb_i[b]) begin
          regs_q[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // Same-edge write is not visible here, old value wins
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_q <= regs_q[rd_idx_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// ==== design/axil_reg_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_reg_ctrl
  import axil_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  axil_req_t                req_i,
  output axil_rsp_t                rsp_o,
  output logic                     wr_en_o,
  output logic [REG_IDX_WIDTH-1:0] wr_idx_o,
  output data_t                    wr_data_o,
  output strb_t                    wr_strb_o,
  output logic                     rd_en_o,
  output logic [REG_IDX_WIDTH-1:0] rd_idx_o,
  input  data_t                    rd_data_i
);

  logic       b_pend_q;
  logic       r_pend_q;
  resp_t_code b_resp_q;
  resp_t_code r_resp_q;
  logic       wr_fire;
  logic       rd_fire;
  logic       wr_addr_ok;
  logic       rd_addr_ok;

  // Word aligned and inside the bank
  function automatic logic addr_ok(addr_t addr);
    return (addr[BYTE_OFFSET-1:0] == '0) && (addr[ADDR_WIDTH-1:BYTE_OFFSET] < NUM_REGS);
  endfunction

  // Address and data are taken together, one write at a time
  assign wr_fire    = req_i.aw_valid & req_i.w_valid & ~b_pend_q;
  assign rd_fire    = req_i.ar_valid & ~r_pend_q;
  assign wr_addr_ok = addr_ok(req_i.aw.addr);
  assign rd_addr_ok = addr_ok(req_i.ar.addr);

  assign wr_en_o   = wr_fire & wr_addr_ok;
  assign wr_idx_o  = req_i.aw.addr[BYTE_OFFSET +: REG_IDX_WIDTH];
  assign wr_data_o = req_i.w.data;
  assign wr_strb_o = req_i.w.strb;
  assign rd_en_o   = rd_fire & rd_addr_ok;
  assign rd_idx_o  = req_i.ar.addr[BYTE_OFFSET +: REG_IDX_WIDTH];

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = wr_fire;
    rsp_o.w_ready  = wr_fire;
    rsp_o.b.resp   = b_resp_q;
    rsp_o.b_valid  = b_pend_q;
    rsp_o.ar_ready = ~r_pend_q;
    // Bank output is stale on an error, so force zero data
    rsp_o.r.data   = (r_resp_q == RESP_OKAY) ? rd_data_i : '0;
    rsp_o.r.resp   = r_resp_q;
    rsp_o.r_valid  = r_pend_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_pend_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_pend_q <= 1'b0;
      end
      if (rd_fire) begin
        r_pend_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // Response codes
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_addr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_resp_q <= rd_addr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // A write address waiting for its data keeps its payload
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.aw_valid && !rsp_o.aw_ready |=> req_i.aw_valid && $stable(req_i.aw));

  // Write data waiting for its address keeps its payload
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.w_valid && !rsp_o.w_ready |=> req_i.w_valid && $stable(req_i.w));

endmodule

`default_nettype wire

// ==== design/axil_spill_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_spill_reg #(
  parameter type chan_t = logic
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  chan_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output chan_t data_o
);

  // Slot A drives the output, slot B catches the overflow beat
  logic  a_full_q, a_full_d;
  logic  b_full_q, b_full_d;
  chan_t a_data_q, a_data_d;
  chan_t b_data_q, b_data_d;
  logic  ready_q;
  logic  in_fire;
  logic  out_fire;

  assign in_fire  = valid_i & ready_q;
  assign out_fire = a_full_q & ready_i;

  always_comb begin
    a_full_d = a_full_q;
    a_data_d = a_data_q;
    b_full_d = b_full_q;
    b_data_d = b_data_q;
    if (out_fire || !a_full_q) begin
      // A frees up, refill from B first to keep order
      if (b_full_q) begin
        a_full_d = 1'b1;
        a_data_d = b_data_q;
        b_full_d = 1'b0;
      end else begin
        a_full_d = in_fire;
        a_data_d = data_i;
      end
    end else if (in_fire) begin
      // A stalled, park the new beat in B
      b_full_d = 1'b1;
      b_data_d = data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      // Ready tracks a free overflow slot, one cycle late out of reset
      ready_q  <= ~b_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    a_data_q <= a_data_d;
    b_data_q <= b_data_d;
  end

  assign ready_o = ready_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;

  // A stalled beat must stay put until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// ==== design/axil_sub_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_sub_top
  import axil_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o
);

  axil_req_t                cut_req;
  axil_rsp_t                cut_rsp;
  logic                     wr_en;
  logic [REG_IDX_WIDTH-1:0] wr_idx;
  data_t                    wr_data;
  strb_t                    wr_strb;
  logic                     rd_en;
  logic [REG_IDX_WIDTH-1:0] rd_idx;
  data_t                    rd_data;

  axil_multicut #(.NumCuts(NUM_CUTS)) i_multicut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .slv_req_i (req_i),
    .slv_rsp_o (rsp_o),
    .mst_req_o (cut_req),
    .mst_rsp_i (cut_rsp)
  );

  axil_reg_ctrl i_reg_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (cut_req),
    .rsp_o     (cut_rsp),
    .wr_en_o   (wr_en),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb),
    .rd_en_o   (rd_en),
    .rd_idx_o  (rd_idx),
    .rd_data_i (rd_data)
  );

  axil_reg_bank i_reg_bank (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (wr_en),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_en_i   (rd_en),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module tb_axil_sub \
  -o Vtb_axil_sub

./obj_dir/Vtb_axil_sub > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
echo "run.sh: testbench did not report a pass"
exit 1

// ==== test/tb_axil_sub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axil_sub
  import axil_pkg::*;
();

  localparam int          CLK_PERIOD = 40;
  localparam logic [31:0] SEED       = 32'd12432;
  localparam int          N_RAND     = 24;
  localparam int          N_BAD      = 8;
  localparam int          N_B2B      = 48;
  // Operations issued over all phases
  localparam int          NUM_OPS    = 3 * NUM_REGS + 5 * N_RAND + 2 * N_BAD + N_B2B;

  logic        clk_i = 1'b0;
  logic        reset_i;
  axil_req_t   req_drv;
  axil_req_t   req;
  axil_rsp_t   rsp;
  logic        b_ready;
  logic        r_ready;
  logic        rand_ready;
  logic [31:0] rnd;
  data_t       shadow [NUM_REGS];
  resp_t_code  b_exp_q [$];
  r_chan_t     r_exp_q [$];
  int          checks = 0;
  int          errors = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Response readies come from their own process
  always_comb begin
    req         = req_drv;
    req.b_ready = b_ready;
    req.r_ready = r_ready;
  end

  axil_sub_top axil_sub_top_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic addr_t reg_addr(input int unsigned idx);
    return addr_t'(idx * STRB_WIDTH);
  endfunction

  // Word aligned and inside the bank
  function automatic logic addr_valid(input addr_t addr);
    return (addr % STRB_WIDTH == 0) && (addr / STRB_WIDTH < NUM_REGS);
  endfunction

  function automatic r_chan_t expected_read(input addr_t addr);
    r_chan_t res;
    res.data = '0;
    res.resp = RESP_SLVERR;
    if (addr_valid(addr)) begin
      res.data = shadow[addr / STRB_WIDTH];
      res.resp = RESP_OKAY;
    end
    return res;
  endfunction

  // Only strobed bytes change
  task automatic shadow_write(input addr_t addr, input data_t data, input strb_t strb);
    int unsigned idx;
    if (addr_valid(addr)) begin
      idx = addr / STRB_WIDTH;
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) begin
          shadow[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  // AW and W are offered together, each drops on its own transfer
  task automatic write_op(input addr_t addr, input data_t data, input strb_t strb);
    logic aw_done;
    logic w_done;
    b_exp_q.push_back(addr_valid(addr) ? RESP_OKAY : RESP_SLVERR);
    shadow_write(addr, data, strb);
    req_drv.aw.addr = addr;
    req_drv.aw_valid = 1'b1;
    req_drv.w.data = data;
    req_drv.w.strb = strb;
    req_drv.w_valid = 1'b1;
    aw_done = 1'b0;
    w_done = 1'b0;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      if (req_drv.aw_valid && rsp.aw_ready) aw_done = 1'b1;
      if (req_drv.w_valid && rsp.w_ready) w_done = 1'b1;
      @(posedge clk_i);
      #2;
      if (aw_done) req_drv.aw_valid = 1'b0;
      if (w_done) req_drv.w_valid = 1'b0;
    end
  endtask

  // AR stays high across calls, so reads go back to back
  task automatic read_op(input addr_t addr);
    logic done;
    r_exp_q.push_back(expected_read(addr));
    req_drv.ar.addr = addr;
    req_drv.ar_valid = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = rsp.ar_ready;
      @(posedge clk_i);
      #2;
    end
    req_drv.ar_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (b_exp_q.size() != 0 || r_exp_q.size() != 0) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_op(reg_addr(i));
    end
    wait_idle();
  endtask

  initial begin : ready_drive
    logic [31:0] st;
    logic        use_rand;
    st = xorshift(SEED ^ 32'h9e37_79b9);
    b_ready = 1'b0;
    r_ready = 1'b0;
    forever begin
      @(posedge clk_i);
      // Mode is taken at the edge, before the main process moves it
      use_rand = rand_ready;
      #2;
      st = xorshift(st);
      b_ready = use_rand ? st[0] : 1'b1;
      r_ready = use_rand ? st[3] : 1'b1;
    end
  end

  // Responses are sampled mid-cycle, away from both edges
  always @(negedge clk_i) begin : compare
    resp_t_code exp_b;
    r_chan_t    exp_r;
    if (!reset_i && rsp.b_valid && req.b_ready) begin
      if (b_exp_q.size() == 0) begin
        $display("A write response arrived with no write outstanding");
        errors++;
      end else begin
        exp_b = b_exp_q.pop_front();
        checks++;
        assert (rsp.b.resp == exp_b) else begin
          $display("CHECK FAILED rsp_o.b.resp: expected %01h, actual %01h", exp_b, rsp.b.resp);
          errors++;
        end
      end
    end
    if (!reset_i && rsp.r_valid && req.r_ready) begin
      if (r_exp_q.size() == 0) begin
        $display("A read response arrived with no read outstanding");
        errors++;
      end else begin
        exp_r = r_exp_q.pop_front();
        checks++;
        assert (rsp.r.data == exp_r.data) else begin
          $display("CHECK FAILED rsp_o.r.data: expected %08h, actual %08h",
                   exp_r.data, rsp.r.data);
          errors++;
        end
        assert (rsp.r.resp == exp_r.resp) else begin
          $display("CHECK FAILED rsp_o.r.resp: expected %01h, actual %01h",
                   exp_r.resp, rsp.r.resp);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #(NUM_OPS * 60 * CLK_PERIOD);
    $display("Timeout: the run did not finish, responses are still outstanding");
    $display("Closing: %0d checks, %0d errors", checks, errors);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    addr_t       addr;
    int unsigned idx;
    reset_i = 1'b1;
    req_drv = '0;
    rand_ready = 1'b0;
    rnd = SEED;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    // Everything reads zero after reset
    read_all();

    // Full-strobe writes, then random read back
    for (int i = 0; i < N_RAND; i++) begin
      rnd = xorshift(rnd);
      write_op(reg_addr(i % NUM_REGS), rnd, '1);
    end
    wait_idle();
    for (int i = 0; i < N_RAND; i++) begin
      rnd = xorshift(rnd);
      read_op(reg_addr(rnd % NUM_REGS));
    end
    wait_idle();

    // Byte merge under partial strobes
    for (int i = 0; i < N_RAND; i++) begin
      rnd = xorshift(rnd);
      idx = rnd % NUM_REGS;
      rnd = xorshift(rnd);
      write_op(reg_addr(idx), rnd, strb_t'(rnd[7:4]));
    end
    wait_idle();
    read_all();

    // Out of range but aligned, then misaligned inside the bank
    for (int i = 0; i < N_BAD; i++) begin
      rnd = xorshift(rnd);
      if (i % 2 == 0) begin
        addr = {rnd[11:6] | 6'h01, rnd[5:2], 2'b00};
      end else begin
        addr = {6'h00, rnd[5:2], rnd[1:0] | 2'b01};
      end
      write_op(addr, ~rnd, '1);
      read_op(addr);
    end
    wait_idle();
    read_all();

    // Random back-pressure on B and R
    rand_ready = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      rnd = xorshift(rnd);
      idx = rnd % NUM_REGS;
      rnd = xorshift(rnd);
      write_op(reg_addr(idx), rnd, strb_t'(rnd[19:16]));
    end
    wait_idle();
    for (int i = 0; i < N_RAND; i++) begin
      rnd = xorshift(rnd);
      read_op(reg_addr(rnd % NUM_REGS));
    end
    wait_idle();
    rand_ready = 1'b0;

    // Reads every cycle, several in flight in the cuts
    for (int i = 0; i < N_B2B; i++) begin
      read_op(reg_addr(i % NUM_REGS));
    end
    wait_idle();

    repeat (4) @(posedge clk_i);
    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
